/* Makefile */
TOP := mips_system_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* common/mips_pkg.sv */
`default_nettype none

// Shared encodings and bus bundles for the MIPS32-subset core and its memory.
package mips_pkg;

    // Primary opcodes in bits 31:26 of the instruction word.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // Function codes in bits 5:0, only meaningful when the opcode is SPECIAL.
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25
    } funct_e;

    // Operations the ALU can perform.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLL = 3'd4,
        ALU_SRL = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    // Avalon-MM master request. Read and write are never raised together.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
        logic [3:0]  byteenable;
    } avalon_req_t;

    // Avalon-MM slave response. Readdata is valid in the cycle waitrequest is low.
    typedef struct packed {
        logic [31:0] readdata;
        logic        waitrequest;
    } avalon_rsp_t;

    // One preload write into the RAM, addressed by word.
    typedef struct packed {
        logic        valid;
        logic [7:0]  addr;
        logic [31:0] data;
    } ram_load_t;

    // Register v0 holds the result the core exports.
    localparam logic [4:0] REG_V0 = 5'd2;

endpackage

`default_nettype wire

/* files.f */
common/mips_pkg.sv
rtl/cpu/mips_alu.sv
rtl/cpu/mips_regfile.sv
rtl/cpu/mips_cpu.sv
rtl/avalon_ram.sv
rtl/mips_system.sv
tb/mips_system_tb.sv

/* rtl/avalon_ram.sv */
`timescale 1ns/10ps
`default_nettype none

// Single-port word RAM behind an Avalon-MM slave.
// Every access waits one cycle and completes in the next.
module avalon_ram #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mips_pkg::avalon_req_t bus_req,
    output mips_pkg::avalon_rsp_t bus_rsp,
    input  mips_pkg::ram_load_t   load
);

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    logic [31:0]              mem [DEPTH];
    logic                     phase;
    logic                     access;
    logic [RAM_ADDR_BITS-1:0] bus_idx;
    logic [RAM_ADDR_BITS-1:0] load_idx;

    assign access = bus_req.read || bus_req.write;

    // Byte offset is dropped and upper address bits are ignored, so addresses wrap.
    assign bus_idx  = bus_req.address[RAM_ADDR_BITS+1:2];
    assign load_idx = RAM_ADDR_BITS'(load.addr);

    // The phase flag marks the second cycle of an access, the one that completes it.
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= 1'b0;
        end else if (access) begin
            phase <= !phase;
        end else begin
            phase <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[load_idx] <= load.data;
        end else if (bus_req.write && phase) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req.byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= bus_req.writedata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        bus_rsp.waitrequest = access && !phase;
        bus_rsp.readdata    = mem[bus_idx];
    end

endmodule

`default_nettype wire

/* rtl/cpu/mips_alu.sv */
`timescale 1ns/10ps
`default_nettype none

// Combinational ALU for the supported subset.
// Shifts act on b by shamt, as the MIPS shift instructions use rt as the source.
module mips_alu (
    input  mips_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic [4:0]        shamt,
    output logic [31:0]       result,
    output logic              equal
);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = a + b;
            end
            mips_pkg::ALU_SUB: begin
                result = a - b;
            end
            mips_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_pkg::ALU_OR: begin
                result = a | b;
            end
            mips_pkg::ALU_SLL: begin
                result = b << shamt;
            end
            mips_pkg::ALU_SRL: begin
                result = b >> shamt;
            end
            mips_pkg::ALU_LUI: begin
                // The immediate arrives zero extended in b.
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = 32'h0000_0000;
            end
        endcase
    end

    // Branch compare, independent of the selected operation.
    assign equal = (a == b);

endmodule

`default_nettype wire

/* rtl/cpu/mips_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

// Multicycle MIPS32-subset core with an Avalon-MM master.
// Each instruction is fetched, executed, and for LW and SW given one memory access.
module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    output mips_pkg::avalon_req_t bus_req,
    input  mips_pkg::avalon_rsp_t bus_rsp,
    output logic                  active,
    output logic [31:0]           register_v0
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e      state;
    logic        active_q;
    logic [31:0] pc;
    logic [31:0] ir;
    logic        jump_pending;
    logic [31:0] jump_target;

    // Instruction fields.
    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [31:0]       imm_sext;
    logic [31:0]       imm_zext;

    // Decode results.
    mips_pkg::alu_op_e alu_op;
    logic [31:0]       alu_b;
    logic [31:0]       alu_result;
    logic              alu_equal;
    logic              alu_wr;
    logic [4:0]        dest_reg;
    logic              is_lw;
    logic              is_sw;
    logic              take_branch;
    logic [31:0]       branch_target;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        wr_en;
    logic [31:0] wr_data;
    logic        retire;

    assign opcode   = mips_pkg::opcode_e'(ir[31:26]);
    assign funct    = mips_pkg::funct_e'(ir[5:0]);
    assign rs       = ir[25:21];
    assign rt       = ir[20:16];
    assign rd       = ir[15:11];
    assign imm_sext = {{16{ir[15]}}, ir[15:0]};
    assign imm_zext = {16'h0000, ir[15:0]};

    always_comb begin
        alu_op        = mips_pkg::ALU_ADD;
        alu_b         = rt_data;
        alu_wr        = 1'b0;
        dest_reg      = rd;
        is_lw         = 1'b0;
        is_sw         = 1'b0;
        take_branch   = 1'b0;
        // PC still points at the branch, so the target is relative to the delay slot.
        branch_target = pc + 32'd4 + {imm_sext[29:0], 2'b00};
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                alu_wr = 1'b1;
                case (funct)
                    mips_pkg::F_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::F_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::F_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_JR: begin
                        alu_wr        = 1'b0;
                        take_branch   = 1'b1;
                        branch_target = rs_data;
                    end
                    default: alu_wr = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                alu_b    = imm_sext;
                alu_wr   = 1'b1;
                dest_reg = rt;
            end
            mips_pkg::OP_ORI: begin
                alu_op   = mips_pkg::ALU_OR;
                alu_b    = imm_zext;
                alu_wr   = 1'b1;
                dest_reg = rt;
            end
            mips_pkg::OP_LUI: begin
                alu_op   = mips_pkg::ALU_LUI;
                alu_b    = imm_zext;
                alu_wr   = 1'b1;
                dest_reg = rt;
            end
            mips_pkg::OP_LW: begin
                alu_b    = imm_sext;
                dest_reg = rt;
                is_lw    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_b = imm_sext;
                is_sw = 1'b1;
            end
            mips_pkg::OP_BEQ: take_branch = alu_equal;
            mips_pkg::OP_BNE: take_branch = !alu_equal;
            default: ;
        endcase
    end

    // An instruction retires at the end of execute, or when its memory access completes.
    assign retire = active_q &&
                    ((state == S_EXEC && !is_lw && !is_sw) ||
                     (state == S_MEM && !bus_rsp.waitrequest));

    assign wr_en = active_q &&
                   ((state == S_EXEC && alu_wr) ||
                    (state == S_MEM && is_lw && !bus_rsp.waitrequest));
    assign wr_data = is_lw ? bus_rsp.readdata : alu_result;

    // The memory address comes straight from the ALU, whose inputs stay fixed in S_MEM.
    always_comb begin
        bus_req.address    = (state == S_FETCH) ? pc : alu_result;
        bus_req.read       = active_q && (state == S_FETCH || (state == S_MEM && is_lw));
        bus_req.write      = active_q && state == S_MEM && is_sw;
        bus_req.writedata  = rt_data;
        bus_req.byteenable = 4'hF;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_FETCH;
            active_q     <= 1'b0;
            pc           <= RESET_VECTOR;
            jump_pending <= 1'b0;
        end else if (!active_q) begin
            // Start running after reset; a halted core stays down until the next reset.
            if (state != S_HALT) begin
                active_q <= 1'b1;
            end
        end else begin
            case (state)
                S_FETCH: begin
                    if (!bus_rsp.waitrequest) begin
                        ir    <= bus_rsp.readdata;
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_lw || is_sw) begin
                        state <= S_MEM;
                    end
                end
                default: ;
            endcase
            if (retire) begin
                jump_pending <= take_branch;
                if (take_branch) begin
                    jump_target <= branch_target;
                end
                pc <= jump_pending ? jump_target : pc + 32'd4;
                // The delay slot has just completed; a jump to zero ends the run.
                if (jump_pending && jump_target == 32'h0000_0000) begin
                    state    <= S_HALT;
                    active_q <= 1'b0;
                end else begin
                    state <= S_FETCH;
                end
            end
        end
    end

    assign active = active_q;

    mips_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (dest_reg),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (ir[10:6]),
        .result (alu_result),
        .equal  (alu_equal)
    );

endmodule

`default_nettype wire

/* rtl/cpu/mips_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

// General purpose register file with two read ports and one write port.
module mips_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Register zero always reads as zero.
    assign rs_data = (rs_addr == 5'd0) ? 32'h0000_0000 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0000_0000 : regs[rt_addr];

    // The result register is tapped out for the system port.
    assign v0 = regs[mips_pkg::REG_V0];

endmodule

`default_nettype wire

/* rtl/mips_system.sv */
`timescale 1ns/10ps
`default_nettype none

// Top level: the core and its program RAM joined by the Avalon bus.
// Programs are placed in the RAM through the load port while rst is held.
module mips_system #(
    parameter logic [31:0] RESET_VECTOR  = 32'h0000_0000,
    parameter int          RAM_ADDR_BITS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::ram_load_t load,
    output logic                active,
    output logic [31:0]         register_v0
);

    mips_pkg::avalon_req_t bus_req;
    mips_pkg::avalon_rsp_t bus_rsp;

    mips_cpu #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_cpu (
        .clk         (clk),
        .rst         (rst),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_ram (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .load    (load)
    );

endmodule

`default_nettype wire

/* tb/mips_system_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// Testbench for mips_system. Each table row is a short program placed from address 4
// while the core is held in reset. The core then runs until it halts and v0 is checked.
module mips_system_tb;

    localparam int         CYCLES_PER_ROW = 400;
    localparam logic [4:0] R_ZERO = 5'd0;
    localparam logic [4:0] R_V0   = 5'd2;
    localparam logic [4:0] R_T0   = 5'd8;
    localparam logic [4:0] R_T1   = 5'd9;
    localparam logic [4:0] R_T2   = 5'd10;
    localparam logic [4:0] R_T3   = 5'd11;

    // Up to eight program words, first word at index 0, and the value v0 holds at the halt.
    typedef struct packed {
        logic [0:7][31:0] prog;
        logic [31:0]      expect_v0;
    } test_row_t;

    logic                clk;
    logic                rst;
    logic                rst_q = 1'b0;
    mips_pkg::ram_load_t load;
    logic                active;
    logic [31:0]         register_v0;

    test_row_t   rows [$];
    string       row_names [$];
    logic [31:0] rng_state;
    int          value_errors = 0;
    int          bus_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic        seen_active = 1'b0;
    logic        halted = 1'b0;

    mips_system #(
        .RESET_VECTOR (32'd4)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .active      (active),
        .register_v0 (register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_reg(input logic [5:0] funct, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    task automatic add_row(input string name, input logic [0:7][31:0] prog,
                           input logic [31:0] expect_v0);
        test_row_t row;
        row.prog      = prog;
        row.expect_v0 = expect_v0;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] halt_jr;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] t3;
        logic [15:0] i1;
        logic [15:0] i2;
        logic [15:0] i3;
        logic [4:0]  s1;
        halt_jr = enc_reg(mips_pkg::F_JR, R_ZERO, R_ZERO, R_ZERO, 5'd0);
        // v0 becomes 28 and is the JR target. The delay slot adds 0x50, the word at 24 is
        // skipped and the target adds 0x54.
        add_row("delay slot", {
            enc_imm(mips_pkg::OP_ADDIU, R_ZERO, R_V0, 16'd3),
            enc_reg(mips_pkg::F_SLL, R_ZERO, R_V0, R_V0, 5'd3),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'd4),
            enc_reg(mips_pkg::F_JR, R_V0, R_ZERO, R_ZERO, 5'd0),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0050),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0100),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0054),
            halt_jr}, 32'h0000_00C0);
        // Word 254 is written and read back, then a write to register zero must not stick.
        add_row("store then load", {
            enc_imm(mips_pkg::OP_LUI, R_ZERO, R_T0, 16'h1234),
            enc_imm(mips_pkg::OP_ORI, R_T0, R_T0, 16'h5678),
            enc_imm(mips_pkg::OP_ORI, R_ZERO, R_T1, 16'h03F0),
            enc_imm(mips_pkg::OP_SW, R_T1, R_T0, 16'd8),
            enc_imm(mips_pkg::OP_LW, R_T1, R_V0, 16'd8),
            enc_imm(mips_pkg::OP_ADDIU, R_ZERO, R_ZERO, 16'd5),
            enc_reg(mips_pkg::F_ADDU, R_V0, R_ZERO, R_V0, 5'd0),
            halt_jr}, 32'h1234_5678);
        add_row("beq taken, bne not taken", {
            enc_imm(mips_pkg::OP_ADDIU, R_ZERO, R_T0, 16'd5),
            enc_imm(mips_pkg::OP_BEQ, R_T0, R_T0, 16'd2),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0001),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0010),
            enc_imm(mips_pkg::OP_BNE, R_T0, R_T0, 16'd2),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0001),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0100),
            halt_jr}, 32'h0000_0102);
        add_row("beq not taken, bne taken", {
            enc_imm(mips_pkg::OP_ADDIU, R_ZERO, R_T1, 16'd7),
            enc_imm(mips_pkg::OP_BEQ, R_ZERO, R_T1, 16'd2),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0001),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0010),
            enc_imm(mips_pkg::OP_BNE, R_ZERO, R_T1, 16'd2),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0001),
            enc_imm(mips_pkg::OP_ADDIU, R_V0, R_V0, 16'h0100),
            halt_jr}, 32'h0000_0012);
        for (int k = 0; k < 2; k++) begin
            r1 = next_random();
            r2 = next_random();
            i1 = r1[15:0];
            i2 = r1[31:16];
            i3 = r2[15:0];
            s1 = r2[20:16];
            t0 = {i1, 16'h0000} | {16'h0000, i2};
            t1 = {{16{i3[15]}}, i3};
            t2 = t0 + t1;
            t3 = t2 << s1;
            add_row("random lui/ori/addiu/addu/sll/subu", {
                enc_imm(mips_pkg::OP_LUI, R_ZERO, R_T0, i1),
                enc_imm(mips_pkg::OP_ORI, R_T0, R_T0, i2),
                enc_imm(mips_pkg::OP_ADDIU, R_ZERO, R_T1, i3),
                enc_reg(mips_pkg::F_ADDU, R_T0, R_T1, R_T2, 5'd0),
                enc_reg(mips_pkg::F_SLL, R_ZERO, R_T2, R_T3, s1),
                enc_reg(mips_pkg::F_SUBU, R_T3, R_T1, R_V0, 5'd0),
                halt_jr, 32'h0000_0000}, t3 - t1);
            r1 = next_random();
            r2 = next_random();
            i1 = r1[15:0];
            i2 = r1[31:16];
            s1 = r2[4:0];
            t0 = {{16{i1[15]}}, i1};
            t1 = {16'h0000, i2};
            add_row("random addiu/ori/and/srl/or", {
                enc_imm(mips_pkg::OP_ADDIU, R_ZERO, R_T0, i1),
                enc_imm(mips_pkg::OP_ORI, R_ZERO, R_T1, i2),
                enc_reg(mips_pkg::F_AND, R_T0, R_T1, R_T2, 5'd0),
                enc_reg(mips_pkg::F_SRL, R_ZERO, R_T0, R_T3, s1),
                enc_reg(mips_pkg::F_OR, R_T2, R_T3, R_V0, 5'd0),
                halt_jr, 32'h0000_0000, 32'h0000_0000}, (t0 & t1) | (t0 >> s1));
        end
    endtask

    // Reset is held while all 256 words are written, program words at 1 to 8.
    task automatic run_row(input int idx);
        logic [31:0] word;
        logic [2:0]  slot;
        @(posedge clk);
        rst <= 1'b1;
        for (int w = 0; w < 256; w++) begin
            slot = 3'(w - 1);
            word = (w >= 1 && w <= 8) ? rows[idx].prog[slot] : 32'h0000_0000;
            @(posedge clk);
            load.valid <= 1'b1;
            load.addr  <= 8'(w);
            load.data  <= word;
        end
        @(posedge clk);
        load.valid <= 1'b0;
        rst        <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (active === 1'b1) else begin
            value_errors++;
            $display("[ERROR] %0t: %s: active low after reset release", $time, row_names[idx]);
        end
        while (active === 1'b1) begin
            @(negedge clk);
        end
        assert (register_v0 === rows[idx].expect_v0) else begin
            value_errors++;
            $display("[ERROR] %0t: %s: v0 = %h, expected %h", $time, row_names[idx],
                     register_v0, rows[idx].expect_v0);
        end
    endtask

    always @(posedge clk) begin
        rst_q  <= rst;
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // The bus must stay idle in reset, and once halted the core stays down until reset.
    always @(negedge clk) begin
        if (rst_q) begin
            seen_active = 1'b0;
            halted      = 1'b0;
        end else if (active) begin
            seen_active = 1'b1;
        end
        if (seen_active && !active) begin
            halted = 1'b1;
        end
        if (rst_q || halted) begin
            assert (!u_dut.bus_req.read && !u_dut.bus_req.write && !active) else begin
                bus_errors++;
                $display("[ERROR] %0t: bus request or active seen while %s", $time,
                         rst_q ? "in reset" : "halted");
            end
        end
    end

    initial begin
        rst       = 1'b1;
        load      = '0;
        rng_state = 32'd13179;
        build_table();
        cycle_limit = rows.size() * CYCLES_PER_ROW;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("Rows run: %0d, value errors: %0d, bus errors: %0d",
                 rows.size(), value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
